// File: files.f
+incdir+include
hw/cop_ctrl_pkg.sv
hw/cop_reg_pkg.sv
hw/cop_ctrl_if.sv
hw/cop_regs.sv
hw/cop_count.sv
hw/cop_top.sv
tb/cop_checker.sv
tb/cop_assert.sv
tb/cop_tb.sv

// File: hw/cop_count.sv
//////////////////////////////
// COP watchdog counter on the startup oscillator
// Counts down from the timeout, raises the interrupt and the COP reset,
// and hands its count back to bus_clk through a resynchronizer
//////////////////////////////

`timescale 1ns/1ps
`include "cop_macros.svh"

module cop_count #(parameter int COUNT_SIZE = `COP_COUNT_SIZE)
  (
  input  logic        bus_clk,        // Control bus clock
  input  logic        async_rst_b,    // Async reset, active low
  input  logic        por_reset_i,    // Power on reset, active low
  input  logic        startup_osc_i,  // Counter clock
  input  logic        debug_mode_i,   // System debug mode
  input  logic        wait_mode_i,    // System wait mode
  input  logic        stop_mode_i,    // System stop mode
  output logic        cop_rst_o,      // COP reset, high until reload
  output logic        cop_irq_o,      // Threshold interrupt
  cop_ctrl_if.count_mp ctrl           // From the register block
  );

  logic [COUNT_SIZE-1:0] cop_counter;   // Live count, oscillator domain
  logic [COUNT_SIZE-1:0] capture_q;     // Count in bus_clk domain
  logic                  freeze;        // Mode with matching enable
  logic                  reload_1;      // Stretcher, bus side
  logic                  reload_2;      // Stretcher, oscillator side
  logic                  osc_sync1;
  logic                  osc_sync2;
  logic                  osc_rise;      // Oscillator edge seen in bus_clk
  logic                  irq_dec;
  logic                  irq_q;
  logic                  event_q;
  logic                  event_clr;

  assign freeze = (debug_mode_i && ctrl.debug_ena) ||
                  (wait_mode_i  && ctrl.wait_ena)  ||
                  (stop_mode_i  && ctrl.stop_ena);

  ////////////////////////////// Oscillator domain
  // Counter stops at zero, reset stays up until reload
  always_ff @(posedge startup_osc_i or negedge async_rst_b)
  begin
    if (!async_rst_b)
      cop_counter <= '1;
    else if (reload_2)
      cop_counter <= ctrl.timeout_value;
    else if (!freeze && (cop_counter != '0))
      cop_counter <= cop_counter - 1'b1;
  end

  always_ff @(posedge startup_osc_i or negedge por_reset_i)
  begin
    if (!por_reset_i)
      cop_rst_o <= 1'b0;
    else if (reload_2)
      cop_rst_o <= 1'b0;
    else
      cop_rst_o <= cop_rst_o || (cop_counter == '0);  // One cycle after zero
  end

  // Second stage of the stretcher, also the reload strobe
  always_ff @(posedge startup_osc_i or negedge por_reset_i)
  begin
    if (!por_reset_i)
      reload_2 <= 1'b1;                     // Start out reloaded
    else
      reload_2 <= reload_1;
  end

  ////////////////////////////// Bus domain
  // Hold the request until the oscillator side picks it up
  // A disable keeps it asserted
  always_ff @(posedge bus_clk or negedge async_rst_b)
  begin
    if (!async_rst_b)
      reload_1 <= 1'b0;
    else
      reload_1 <= ctrl.reload_count || !ctrl.cop_ena || (reload_1 && !reload_2);
  end

  // Edge detect on the oscillator, sample count once per period
  always_ff @(posedge bus_clk or negedge async_rst_b)
  begin
    if (!async_rst_b)
    begin
      osc_sync1 <= 1'b0;
      osc_sync2 <= 1'b0;
      capture_q <= '1;
    end
    else
    begin
      osc_sync1 <= startup_osc_i;
      osc_sync2 <= osc_sync1;
      if (osc_rise)
        capture_q <= cop_counter;           // Count stable half a period after edge
    end
  end

  assign osc_rise = osc_sync1 && !osc_sync2;

  // Threshold decode
  always_comb
  begin
    case (ctrl.irq_sel)
      cop_ctrl_pkg::IRQ_LE16: irq_dec = (cop_counter <= COUNT_SIZE'(16));
      cop_ctrl_pkg::IRQ_LE32: irq_dec = (cop_counter <= COUNT_SIZE'(32));
      cop_ctrl_pkg::IRQ_LE64: irq_dec = (cop_counter <= COUNT_SIZE'(64));
      default:                irq_dec = 1'b0;
    endcase
  end

  always_ff @(posedge bus_clk or negedge async_rst_b)
  begin
    if (!async_rst_b)
    begin
      irq_q     <= 1'b0;
      cop_irq_o <= 1'b0;
    end
    else
    begin
      irq_q     <= irq_dec;                 // Two flop resync
      cop_irq_o <= irq_q;
    end
  end

  // Sticky event, cleared by STATUS write or reload
  assign event_clr = ctrl.reload_count || ctrl.clear_event;

  always_ff @(posedge bus_clk or negedge por_reset_i)
  begin
    if (!por_reset_i)
      event_q <= 1'b0;
    else
      event_q <= cop_rst_o || (event_q && !event_clr);
  end

  assign ctrl.cop_capture = capture_q;
  assign ctrl.cop_event   = event_q;

endmodule

// File: hw/cop_ctrl_if.sv
//////////////////////////////
// Control settings and commands from the register block to the counter
// Status comes back the other way; one modport per side
//////////////////////////////

`timescale 1ns/1ps
`include "cop_macros.svh"

interface cop_ctrl_if #(parameter int COUNT_SIZE = `COP_COUNT_SIZE);

  logic                       cop_ena;        // Counter enable, held reloaded when low
  logic                       debug_ena;      // Freeze in debug mode
  logic                       wait_ena;       // Freeze in wait mode
  logic                       stop_ena;       // Freeze in stop mode
  cop_ctrl_pkg::cop_irq_sel_e irq_sel;        // Interrupt threshold
  logic [COUNT_SIZE-1:0]      timeout_value;  // Reload value
  logic                       reload_count;   // One cycle pulse, good key pair
  logic                       clear_event;    // One cycle pulse, STATUS write of 1

  logic [COUNT_SIZE-1:0]      cop_capture;    // Count in bus_clk domain
  logic                       cop_event;      // Sticky timeout status

  modport regs_mp (
    output cop_ena, debug_ena, wait_ena, stop_ena, irq_sel, timeout_value,
           reload_count, clear_event,
    input  cop_capture, cop_event
  );

  modport count_mp (
    input  cop_ena, debug_ena, wait_ena, stop_ena, irq_sel, timeout_value,
           reload_count, clear_event,
    output cop_capture, cop_event
  );

endinterface

// File: hw/cop_ctrl_pkg.sv
//////////////////////////////
// Watchdog control types shared by the register block and the counter
//////////////////////////////

package cop_ctrl_pkg;

  // Interrupt threshold select, CTRL bits 5:4
  typedef enum logic [1:0] {
    IRQ_OFF  = 2'b00,  // No interrupt
    IRQ_LE16 = 2'b01,  // Count at or below 16
    IRQ_LE32 = 2'b10,
    IRQ_LE64 = 2'b11
  } cop_irq_sel_e;

  // Service key checker states
  typedef enum logic {
    KEY_IDLE     = 1'b0,
    KEY_GOT_KEY1 = 1'b1   // First key seen, waiting for second
  } cop_key_state_e;

endpackage

// File: hw/cop_reg_pkg.sv
//////////////////////////////
// Register map and bus operation types of the COP control bus
// Referenced by scoped name from the register block and the top level
//////////////////////////////

`include "cop_macros.svh"

package cop_reg_pkg;

  // Register addresses, anything above COUNT reads as zero
  typedef enum logic [`COP_ADDR_W-1:0] {
    CTRL    = 3'd0,  // Enables and irq select
    TOUT    = 3'd1,  // Timeout reload value
    SERVICE = 3'd2,  // Key writes, reads zero
    STATUS  = 3'd3,  // Bit 0 event, write 1 to clear
    COUNT   = 3'd4   // Read only count capture
  } cop_addr_e;

  // Single beat bus operation
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cop_op_e;

endpackage

// File: hw/cop_regs.sv
//////////////////////////////
// COP register block on the valid/ready control bus
// Holds CTRL and TOUT, checks the service key pair, returns reads
// with a response that waits for rready
//////////////////////////////

`timescale 1ns/1ps
`include "cop_macros.svh"

module cop_regs
  (
  input  logic                            bus_clk,       // Control bus clock
  input  logic                            async_rst_b,   // Async reset, active low
  input  logic                            bus_valid_i,   // Request valid
  output logic                            bus_ready_o,   // Request accepted
  input  cop_reg_pkg::cop_op_e            bus_op_i,      // Read or write
  input  cop_reg_pkg::cop_addr_e          bus_addr_i,    // Register address
  input  logic [`COP_DATA_W-1:0]          bus_wdata_i,   // Write data
  output logic [`COP_DATA_W-1:0]          bus_rdata_o,   // Read response data
  output logic                            bus_rvalid_o,  // Read response valid
  input  logic                            bus_rready_i,  // Response taken
  cop_ctrl_if.regs_mp                     ctrl           // To the counter
  );

  localparam int DW = `COP_DATA_W;

  // Register state
  logic                           cop_ena_q;
  logic                           debug_ena_q;
  logic                           wait_ena_q;
  logic                           stop_ena_q;
  cop_ctrl_pkg::cop_irq_sel_e     irq_sel_q;
  logic [`COP_COUNT_SIZE-1:0]     tout_q;

  // Service checker
  cop_ctrl_pkg::cop_key_state_e   key_state;
  cop_ctrl_pkg::cop_key_state_e   key_state_nxt;
  logic                           reload_nxt;
  logic                           reload_q;
  logic                           clear_q;

  // Bus side
  logic                           xfer;
  logic                           wr_en;
  logic                           rd_en;
  logic [DW-1:0]                  rd_mux;
  logic                           rvalid_q;
  logic [DW-1:0]                  rdata_q;

  ////////////////////////////// Request handshake
  // Stall new requests while a response sits unread
  assign bus_ready_o = !(rvalid_q && !bus_rready_i);
  assign xfer        = bus_valid_i && bus_ready_o;
  assign wr_en       = xfer && (bus_op_i == cop_reg_pkg::OP_WRITE);
  assign rd_en       = xfer && (bus_op_i == cop_reg_pkg::OP_READ);

  ////////////////////////////// Control registers
  always_ff @(posedge bus_clk or negedge async_rst_b)
  begin
    if (!async_rst_b)
    begin
      cop_ena_q   <= 1'b0;                      // Counter held reloaded
      debug_ena_q <= 1'b0;
      wait_ena_q  <= 1'b0;
      stop_ena_q  <= 1'b0;
      irq_sel_q   <= cop_ctrl_pkg::IRQ_OFF;
      tout_q      <= `COP_TOUT_RST;
    end
    else if (wr_en)
    begin
      if (bus_addr_i == cop_reg_pkg::CTRL)
      begin
        cop_ena_q   <= bus_wdata_i[0];
        debug_ena_q <= bus_wdata_i[1];
        wait_ena_q  <= bus_wdata_i[2];
        stop_ena_q  <= bus_wdata_i[3];
        irq_sel_q   <= cop_ctrl_pkg::cop_irq_sel_e'(bus_wdata_i[5:4]);
      end
      if (bus_addr_i == cop_reg_pkg::TOUT)
        tout_q <= bus_wdata_i[`COP_COUNT_SIZE-1:0];
    end
  end

  ////////////////////////////// Service key checker
  // KEY1 then KEY2 reloads; any other SERVICE write drops back to idle
  always_comb
  begin
    key_state_nxt = key_state;
    reload_nxt    = 1'b0;
    if (wr_en && (bus_addr_i == cop_reg_pkg::SERVICE))
    begin
      case (key_state)
        cop_ctrl_pkg::KEY_IDLE:
        begin
          if (bus_wdata_i == `COP_KEY1)
            key_state_nxt = cop_ctrl_pkg::KEY_GOT_KEY1;
        end
        cop_ctrl_pkg::KEY_GOT_KEY1:
        begin
          key_state_nxt = cop_ctrl_pkg::KEY_IDLE;
          reload_nxt    = (bus_wdata_i == `COP_KEY2);   // Wrong key, no reload
        end
        default: key_state_nxt = cop_ctrl_pkg::KEY_IDLE;
      endcase
    end
  end

  always_ff @(posedge bus_clk or negedge async_rst_b)
  begin
    if (!async_rst_b)
    begin
      key_state <= cop_ctrl_pkg::KEY_IDLE;
      reload_q  <= 1'b0;
      clear_q   <= 1'b0;
    end
    else
    begin
      key_state <= key_state_nxt;
      reload_q  <= reload_nxt;                // One cycle pulse
      clear_q   <= wr_en && (bus_addr_i == cop_reg_pkg::STATUS) && bus_wdata_i[0];
    end
  end

  ////////////////////////////// Read path
  always_comb
  begin
    case (bus_addr_i)
      cop_reg_pkg::CTRL:
        rd_mux = DW'({irq_sel_q, stop_ena_q, wait_ena_q, debug_ena_q, cop_ena_q});
      cop_reg_pkg::TOUT:   rd_mux = DW'(tout_q);
      cop_reg_pkg::STATUS: rd_mux = DW'(ctrl.cop_event);
      cop_reg_pkg::COUNT:  rd_mux = DW'(ctrl.cop_capture);
      default:             rd_mux = '0;     // SERVICE and unmapped
    endcase
  end

  // Response loads on the read transfer, holds until rready
  always_ff @(posedge bus_clk or negedge async_rst_b)
  begin
    if (!async_rst_b)
    begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end
    else if (rd_en)
    begin
      rvalid_q <= 1'b1;
      rdata_q  <= rd_mux;
    end
    else if (bus_rready_i)
      rvalid_q <= 1'b0;                     // Response taken
  end

  assign bus_rvalid_o = rvalid_q;
  assign bus_rdata_o  = rdata_q;

  ////////////////////////////// To the counter
  assign ctrl.cop_ena       = cop_ena_q;
  assign ctrl.debug_ena     = debug_ena_q;
  assign ctrl.wait_ena      = wait_ena_q;
  assign ctrl.stop_ena      = stop_ena_q;
  assign ctrl.irq_sel       = irq_sel_q;
  assign ctrl.timeout_value = tout_q;
  assign ctrl.reload_count  = reload_q;
  assign ctrl.clear_event   = clear_q;

endmodule

// File: hw/cop_top.sv
//////////////////////////////
// COP watchdog top level
// Joins the register block and the counter, exposes plain bus ports
//////////////////////////////

`timescale 1ns/1ps
`include "cop_macros.svh"

module cop_top
  (
  input  logic                    bus_clk,        // Control bus clock
  input  logic                    async_rst_b,    // Async reset, active low
  input  logic                    por_reset_i,    // Power on reset, active low
  input  logic                    startup_osc_i,  // Watchdog oscillator

  // System modes
  input  logic                    debug_mode_i,
  input  logic                    wait_mode_i,
  input  logic                    stop_mode_i,

  // Control bus request
  input  logic                    bus_valid_i,
  output logic                    bus_ready_o,
  input  cop_reg_pkg::cop_op_e    bus_op_i,
  input  cop_reg_pkg::cop_addr_e  bus_addr_i,
  input  logic [`COP_DATA_W-1:0]  bus_wdata_i,

  // Read response
  output logic [`COP_DATA_W-1:0]  bus_rdata_o,
  output logic                    bus_rvalid_o,
  input  logic                    bus_rready_i,

  // Watchdog outputs
  output logic                    cop_rst_o,      // COP reset request
  output logic                    cop_irq_o       // Early warning interrupt
  );

  // Settings down, status up
  cop_ctrl_if #(.COUNT_SIZE(`COP_COUNT_SIZE)) ctrl_if ();

  ////////////////////////////// Register block
  cop_regs regs_i (
    .bus_clk      (bus_clk),
    .async_rst_b  (async_rst_b),
    .bus_valid_i  (bus_valid_i),
    .bus_ready_o  (bus_ready_o),
    .bus_op_i     (bus_op_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rdata_o  (bus_rdata_o),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rready_i (bus_rready_i),
    .ctrl         (ctrl_if.regs_mp)
  );

  ////////////////////////////// Counter
  cop_count #(.COUNT_SIZE(`COP_COUNT_SIZE)) count_i (
    .bus_clk       (bus_clk),
    .async_rst_b   (async_rst_b),
    .por_reset_i   (por_reset_i),
    .startup_osc_i (startup_osc_i),
    .debug_mode_i  (debug_mode_i),
    .wait_mode_i   (wait_mode_i),
    .stop_mode_i   (stop_mode_i),
    .cop_rst_o     (cop_rst_o),
    .cop_irq_o     (cop_irq_o),
    .ctrl          (ctrl_if.count_mp)
  );

endmodule

// File: include/cop_macros.svh
//////////////////////////////
// Shared widths, service keys and register reset values for the COP watchdog
// Included by the packages, the interface and the RTL that need them
//////////////////////////////

`ifndef COP_MACROS_SVH
`define COP_MACROS_SVH

////////////////////////////// Widths
`define COP_COUNT_SIZE 16      // Watchdog counter and timeout width
`define COP_DATA_W     16      // Control bus data width
`define COP_ADDR_W     3       // Control bus address width

////////////////////////////// Service keys
// Must be written to SERVICE in this order to reload
`define COP_KEY1       16'h5555
`define COP_KEY2       16'hAAAA

////////////////////////////// Reset values
`define COP_TOUT_RST   16'hFFFF  // Longest timeout out of reset

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the COP watchdog testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module cop_tb -o cop_sim
./obj_dir/cop_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0

// File: tb/cop_assert.sv
//////////////////////////////
// Bus handshake assertions, bound into the register block
//////////////////////////////

`timescale 1ns/1ps

module cop_assert
  (
  input logic                 bus_clk,
  input logic                 async_rst_b,
  input logic                 bus_valid_i,
  input cop_reg_pkg::cop_op_e bus_op_i,
  input logic                 bus_ready_o,
  input logic                 bus_rvalid_o,
  input logic                 bus_rready_i,
  input logic [15:0]          bus_rdata_o
  );

  logic rd_pending;   // Read accepted, response not yet taken

  // Pending state seen from the port handshake alone
  always @(posedge bus_clk or negedge async_rst_b)
  begin
    if (!async_rst_b)
      rd_pending <= 1'b0;
    else if (bus_valid_i && bus_ready_o && (bus_op_i == cop_reg_pkg::OP_READ))
      rd_pending <= 1'b1;
    else if (bus_rvalid_o && bus_rready_i)
      rd_pending <= 1'b0;                 // Response taken
  end

  // Response held while the host stalls
  rsp_hold: assert property (@(posedge bus_clk) disable iff (!async_rst_b)
    bus_rvalid_o && !bus_rready_i |=> bus_rvalid_o && $stable(bus_rdata_o))
    else $error("read response changed while rready was low");

  stall_ready: assert property (@(posedge bus_clk) disable iff (!async_rst_b)
    rd_pending && !bus_rready_i |-> !bus_ready_o)
    else $error("request accepted while a response was pending");

  rst_idle: assert property (@(posedge bus_clk) !async_rst_b |-> !bus_rvalid_o)
    else $error("read response valid during reset");

endmodule

bind cop_regs cop_assert assert_i (
  .bus_clk      (bus_clk),
  .async_rst_b  (async_rst_b),
  .bus_valid_i  (bus_valid_i),
  .bus_op_i     (bus_op_i),
  .bus_ready_o  (bus_ready_o),
  .bus_rvalid_o (bus_rvalid_o),
  .bus_rready_i (bus_rready_i),
  .bus_rdata_o  (bus_rdata_o)
);

// File: tb/cop_checker.sv
//////////////////////////////
// Watches the DUT bus and outputs, compares against model values
// Prints one line per test and the closing counts
//////////////////////////////

`timescale 1ns/1ps

module cop_checker
  (
  input logic        bus_clk,
  input logic        async_rst_b,
  input logic        bus_rvalid_i,
  input logic        bus_rready_i,
  input logic [15:0] bus_rdata_i,
  input logic        cop_rst_i      // COP reset from the DUT
  );

  int          check_count = 0;
  int          error_count = 0;
  int          test_count  = 0;
  int          test_errors = 0;
  int          rsp_count   = 0;     // Responses taken so far
  logic [15:0] last_rdata  = '0;
  string       test_name   = "";

  // Response transfers on valid and ready
  always @(posedge bus_clk)
  begin
    if (async_rst_b && bus_rvalid_i && bus_rready_i)
    begin
      last_rdata <= bus_rdata_i;
      rsp_count  <= rsp_count + 1;
    end
  end

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    check_count++;
    if (act !== exp)
    begin
      error_count++;
      test_errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic compare_read(input string name, input logic [15:0] exp);
    check_value(name, exp, last_rdata);
  endtask

  task automatic check_rst(input string name, input logic exp);
    check_value(name, 16'(exp), 16'(cop_rst_i));
  endtask

  task automatic report_error(input string what);
    error_count++;
    test_errors++;
    $display("Error in %s: %s", test_name, what);
  endtask

  task automatic end_test();
    test_count++;
    if (test_errors == 0)
      $display("Test %s passed", test_name);
    else
      $display("Test %s failed with %0d mismatches", test_name, test_errors);
  endtask

  task automatic report_counts();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
  endtask

endmodule

// File: tb/cop_tb.sv
//////////////////////////////
// COP watchdog testbench top
// Clocks, reset, LCG stimulus, bus tasks, test sequence and watchdog
//////////////////////////////

`timescale 1ns/1ps
`include "cop_macros.svh"

module cop_tb;

  localparam int OSC_NS = 40;
  // Worst case test lengths in ns, then margin
  localparam int T_RDBK = 3000;
  localparam int T_TOUT = (32 + 16) * OSC_NS + 2000;
  localparam int T_SERV = (6 * 20 + 20 + 10 + 20 + 10) * OSC_NS + 2000;
  localparam int T_IRQ  = 4 * (110 * OSC_NS + 2000);
  localparam int T_FRZ  = 3 * (30 * OSC_NS + 2000);
  localparam int LIMIT_NS = 2 * (T_RDBK + T_TOUT + T_SERV + T_IRQ + T_FRZ);

  logic bus_clk = 1'b0;
  logic startup_osc_i = 1'b0;
  logic async_rst_b = 1'b0;
  logic por_reset_i = 1'b0;
  logic debug_mode_i = 1'b0;
  logic wait_mode_i = 1'b0;
  logic stop_mode_i = 1'b0;
  logic bus_valid_i = 1'b0;
  cop_reg_pkg::cop_op_e   bus_op_i = cop_reg_pkg::OP_READ;
  cop_reg_pkg::cop_addr_e bus_addr_i = cop_reg_pkg::CTRL;
  logic [15:0] bus_wdata_i = '0;
  logic bus_rready_i = 1'b1;
  logic bus_ready_o, bus_rvalid_o, cop_rst_o, cop_irq_o;
  logic [15:0] bus_rdata_o;
  logic [31:0] lcg_state = 32'h9a94;   // Test stimulus stream
  logic [31:0] rdy_state = 32'h9a94;   // Back-pressure stream
  logic        irq_at_xfer;         // cop_irq_o at the last transfer

  initial forever #5 bus_clk = ~bus_clk;
  initial forever #(OSC_NS / 2) startup_osc_i = ~startup_osc_i;

  cop_top dut_i (.*);

  cop_checker chk_i (.bus_clk(bus_clk), .async_rst_b(async_rst_b), .bus_rvalid_i(bus_rvalid_o),
    .bus_rready_i(bus_rready_i), .bus_rdata_i(bus_rdata_o), .cop_rst_i(cop_rst_o));

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // Random back-pressure, rready high three times in four
  always @(negedge bus_clk)
  begin
    logic [31:0] r;
    r = lcg_next(rdy_state);
    bus_rready_i <= (r[17:16] != 2'b00);
  end

  ////////////////////////////// Bus tasks
  task automatic bus_request(input logic wr, input logic [2:0] addr, input logic [15:0] data);
    logic ok;
    @(negedge bus_clk);
    bus_valid_i <= 1'b1;
    bus_op_i    <= wr ? cop_reg_pkg::OP_WRITE : cop_reg_pkg::OP_READ;
    bus_addr_i  <= cop_reg_pkg::cop_addr_e'(addr);
    bus_wdata_i <= data;
    do
    begin
      #1;
      ok          = bus_ready_o;         // Stable until the next rising edge
      irq_at_xfer = cop_irq_o;
      if (!ok)
        @(negedge bus_clk);
    end while (!ok);
    @(negedge bus_clk);
    bus_valid_i <= 1'b0;
  endtask

  task automatic bus_write(input logic [2:0] addr, input logic [15:0] data);
    bus_request(1'b1, addr, data);
  endtask

  // Leaves the response in chk_i.last_rdata
  task automatic bus_read(input logic [2:0] addr);
    int n;
    int waited;
    n = chk_i.rsp_count;
    waited = 0;
    bus_request(1'b0, addr, 16'h0);
    while (chk_i.rsp_count == n && waited < 100)
    begin
      @(negedge bus_clk);
      waited++;
    end
    if (chk_i.rsp_count == n)
      chk_i.report_error("read response never arrived");
  endtask

  task automatic wait_osc(input int n);
    repeat (n) @(posedge startup_osc_i);
    @(negedge bus_clk);
  endtask

  task automatic wait_rst(input int max_osc);
    int k;
    for (k = 0; k < max_osc * 4 && !cop_rst_o; k++)
      @(negedge bus_clk);
  endtask

  ////////////////////////////// Test sequence
  initial
  begin
    logic [31:0] r;
    logic [15:0] tout, a, thr;
    int i, s;
    repeat (3) @(posedge bus_clk);
    @(negedge bus_clk);
    async_rst_b = 1'b1;
    por_reset_i = 1'b1;

    chk_i.start_test("readback");
    for (i = 0; i < 6; i++)
    begin
      r = lcg_next(lcg_state);
      bus_write(3'd0, r[15:0] & 16'hFFFE);     // Keep the counter disabled
      bus_read(3'd0);
      chk_i.compare_read("CTRL", r[15:0] & 16'h003E);
      bus_write(3'd1, r[31:16]);
      bus_read(3'd1);
      chk_i.compare_read("TOUT", r[31:16]);
      bus_read(3'd5 + 3'(i % 3));
      chk_i.compare_read("unmapped", 16'h0);
    end
    bus_write(3'd0, 16'h0);
    chk_i.end_test();

    chk_i.start_test("timeout");
    r = lcg_next(lcg_state);
    tout = 16'd8 + {11'd0, r[20:16]};
    bus_write(3'd1, tout);
    wait_osc(4);
    bus_write(3'd0, 16'h1);
    wait_rst(int'(tout) + 4);
    chk_i.check_rst("reset rise", 1'b1);
    bus_read(3'd3);
    chk_i.compare_read("STATUS set", 16'h1);
    bus_write(3'd0, 16'h0);                     // Disable drops the reset
    wait_osc(4);
    chk_i.check_rst("reset drop", 1'b0);
    bus_write(3'd3, 16'h1);
    bus_read(3'd3);
    chk_i.compare_read("STATUS clear", 16'h0);
    chk_i.end_test();

    chk_i.start_test("service");
    bus_write(3'd1, 16'd40);
    wait_osc(4);
    bus_write(3'd0, 16'h1);
    for (i = 0; i < 6; i++)
    begin
      wait_osc(20);
      bus_write(3'd2, `COP_KEY1);
      bus_write(3'd2, `COP_KEY2);
      chk_i.check_rst("serviced", 1'b0);
    end
    wait_osc(20);                               // Count about half way down
    bus_write(3'd2, `COP_KEY1);
    bus_write(3'd2, 16'h1234);                  // Wrong second key
    wait_osc(10);
    bus_write(3'd2, `COP_KEY2);                 // Lone second key
    wait_rst(20);                               // Too short if either write reloaded
    chk_i.check_rst("unserviced", 1'b1);
    bus_write(3'd2, `COP_KEY1);
    bus_write(3'd2, `COP_KEY2);
    bus_write(3'd0, 16'h0);
    chk_i.end_test();

    chk_i.start_test("irq thresholds");
    bus_write(3'd1, 16'd100);
    for (s = 0; s < 4; s++)
    begin
      thr = (s == 0) ? 16'd0 : (16'd8 << s);   // 16, 32, 64
      wait_osc(4);
      bus_write(3'd0, 16'h1 | 16'(s << 4));
      for (i = 0; i < 200; i++)
      begin
        bus_read(3'd4);
        a = chk_i.last_rdata;
        if (s == 0)
          chk_i.check_value("irq off", 16'h0, 16'(irq_at_xfer));
        else if (a + 16'd3 <= thr)
          chk_i.check_value("irq below", 16'h1, 16'(irq_at_xfer));
        else if (a > thr + 16'd3)
          chk_i.check_value("irq above", 16'h0, 16'(irq_at_xfer));
        if (a < 16'd4)
          break;
      end
      bus_write(3'd0, 16'h0);
    end
    bus_write(3'd3, 16'h1);
    chk_i.end_test();

    chk_i.start_test("mode freeze");
    bus_write(3'd1, 16'd1000);
    for (s = 1; s < 4; s++)
    begin
      wait_osc(4);
      debug_mode_i = (s == 1);
      wait_mode_i  = (s == 2);
      stop_mode_i  = (s == 3);
      bus_write(3'd0, 16'h1 | (16'h1 << s));
      wait_osc(4);
      bus_read(3'd4);
      a = chk_i.last_rdata;
      wait_osc(8);
      bus_read(3'd4);
      chk_i.compare_read("frozen", a);
      bus_write(3'd0, 16'h1);                   // Enable bit off, mode still on
      wait_osc(2);
      bus_read(3'd4);
      a = chk_i.last_rdata;
      wait_osc(8);
      bus_read(3'd4);
      chk_i.check_value("running", 16'h1, 16'(chk_i.last_rdata < a));
      bus_write(3'd0, 16'h0);
    end
    {debug_mode_i, wait_mode_i, stop_mode_i} = 3'b000;
    chk_i.end_test();

    chk_i.report_counts();
    if (chk_i.error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(LIMIT_NS);
    $display("Timeout: the run did not finish within its time limit");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule
